// ==== logic/bcd_pkg.sv ====
`default_nettype none

package bcd_pkg;

	// ------------------------------------------------------------
	// widths and digit counts
	// ------------------------------------------------------------
	localparam int DIGIT_W     = 4;                      // one packed decimal digit
	localparam int NUM_DIGITS  = 4;                      // halfword mode
	localparam int BYTE_DIGITS = 2;                      // 8-bit accumulator mode
	localparam int WORD_W      = DIGIT_W * NUM_DIGITS;   // 16 bit operands

	typedef logic [DIGIT_W-1:0] bcd_digit_t;
	typedef logic [WORD_W-1:0]  bcd_word_t;

	// ------------------------------------------------------------
	// request and response
	// ------------------------------------------------------------
	typedef struct packed {
		bcd_word_t a;
		bcd_word_t b;
		logic      sub;        // subtract when set
		logic      byte_mode;  // two digit width
		logic      carry_in;   // on subtract, set means no borrow
	} bcd_req_t;

	typedef struct packed {
		bcd_word_t sum;
		logic      carry;      // on subtract, set means no borrow
		logic      zero;
		logic      negative;   // top bit of the selected width
	} bcd_rsp_t;

endpackage

`default_nettype wire

// ==== logic/bcd_operand_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module bcd_operand_stage (
	input  logic              clk,
	input  logic              rst_i,
	input  logic              in_valid_i,
	output logic              in_ready_o,
	input  bcd_pkg::bcd_req_t in_req_i,
	output logic              s1_valid_o,
	input  logic              s1_ready_i,
	output bcd_pkg::bcd_req_t s1_req_o
);
	import bcd_pkg::*;

	logic     s1_valid_q;
	bcd_req_t s1_req_q;
	bcd_req_t req_masked;   // request as it is stored
	logic     in_fire;

	// ------------------------------------------------------------
	// handshake
	// ------------------------------------------------------------

	// free when empty, or when the result stage takes the entry now
	assign in_ready_o = !s1_valid_q || s1_ready_i;
	assign in_fire    = in_valid_i && in_ready_o;

	// ------------------------------------------------------------
	// byte mode operand masking
	// ------------------------------------------------------------
	always_comb begin
		req_masked = in_req_i;
		// upper digits of b go to zero, a keeps its upper byte
		if (in_req_i.byte_mode)
			req_masked.b[WORD_W-1:BYTE_DIGITS*DIGIT_W] = '0;
	end

	// ------------------------------------------------------------
	// stage one register
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i)
			s1_valid_q <= 1'b0;
		else if (in_ready_o)
			s1_valid_q <= in_valid_i;   // load or drain
	end

	always_ff @(posedge clk) begin
		if (in_fire)
			s1_req_q <= req_masked;
	end

	assign s1_valid_o = s1_valid_q;
	assign s1_req_o   = s1_req_q;

	// held operands must not change under a stalled result stage
	property p_s1_hold;
		@(posedge clk) disable iff (rst_i)
		s1_valid_o && !s1_ready_i |=> s1_valid_o && $stable(s1_req_o);
	endproperty

	a_s1_hold: assert property (p_s1_hold)
		else $error("stage one request changed while stalled");

endmodule

`default_nettype wire

// ==== logic/bcd_digit_cell.sv ====
`timescale 1ns/10ps
`default_nettype none

module bcd_digit_cell (
	input  bcd_pkg::bcd_digit_t a_i,
	input  bcd_pkg::bcd_digit_t b_i,
	input  logic                sub_i,
	input  logic                carry_i,
	output bcd_pkg::bcd_digit_t sum_o,
	output logic                carry_o
);
	import bcd_pkg::*;

	typedef logic [DIGIT_W:0] digit_ext_t;   // one spare bit for carry or sign

	digit_ext_t raw;

	always_comb begin
		if (sub_i) begin
			// a - b - borrow, spans -10 .. 9
			raw = digit_ext_t'(a_i) - digit_ext_t'(b_i) - digit_ext_t'(!carry_i);
			if (raw[DIGIT_W]) begin
				raw     = raw + digit_ext_t'(10);   // borrow from the next digit
				carry_o = 1'b0;
			end else begin
				carry_o = 1'b1;
			end
		end else begin
			raw = digit_ext_t'(a_i) + digit_ext_t'(b_i) + digit_ext_t'(carry_i);
			if (raw > digit_ext_t'(9)) begin
				raw     = raw - digit_ext_t'(10);   // decimal adjust
				carry_o = 1'b1;
			end else begin
				carry_o = 1'b0;
			end
		end
		sum_o = raw[DIGIT_W-1:0];
	end

endmodule

`default_nettype wire

// ==== logic/bcd_result_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module bcd_result_stage (
	input  logic              clk,
	input  logic              rst_i,
	input  logic              s1_valid_i,
	output logic              s1_ready_o,
	input  bcd_pkg::bcd_req_t s1_req_i,
	input  bcd_pkg::bcd_word_t digit_sum_i,
	input  logic              carry_byte_i,
	input  logic              carry_word_i,
	output logic              out_valid_o,
	input  logic              out_ready_i,
	output bcd_pkg::bcd_rsp_t out_rsp_o
);
	import bcd_pkg::*;

	logic     out_valid_q;
	bcd_rsp_t rsp_q;
	bcd_rsp_t rsp_next;
	logic     s1_fire;

	// ------------------------------------------------------------
	// handshake
	// ------------------------------------------------------------
	assign s1_ready_o = !out_valid_q || out_ready_i;
	assign s1_fire    = s1_valid_i && s1_ready_o;

	// ------------------------------------------------------------
	// width select and flags
	// ------------------------------------------------------------
	always_comb begin
		if (s1_req_i.byte_mode) begin
			// upper byte of a passes through like the 8-bit accumulator
			rsp_next.sum      = {s1_req_i.a[WORD_W-1:BYTE_DIGITS*DIGIT_W],
			                     digit_sum_i[BYTE_DIGITS*DIGIT_W-1:0]};
			rsp_next.carry    = carry_byte_i;
			rsp_next.zero     = digit_sum_i[BYTE_DIGITS*DIGIT_W-1:0] == '0;
			rsp_next.negative = digit_sum_i[BYTE_DIGITS*DIGIT_W-1];
		end else begin
			rsp_next.sum      = digit_sum_i;
			rsp_next.carry    = carry_word_i;
			rsp_next.zero     = digit_sum_i == '0;
			rsp_next.negative = digit_sum_i[WORD_W-1];
		end
	end

	// ------------------------------------------------------------
	// output register
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i)
			out_valid_q <= 1'b0;
		else if (s1_ready_o)
			out_valid_q <= s1_valid_i;
	end

	always_ff @(posedge clk) begin
		if (s1_fire)
			rsp_q <= rsp_next;
	end

	assign out_valid_o = out_valid_q;
	assign out_rsp_o   = rsp_q;

	property p_out_hold;
		@(posedge clk) disable iff (rst_i)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_rsp_o);
	endproperty

	a_out_hold: assert property (p_out_hold)
		else $error("response changed while stalled");

	// nothing is presented straight out of reset
	a_out_reset: assert property (@(posedge clk) rst_i |=> !out_valid_o)
		else $error("out_valid_o high after reset");

endmodule

`default_nettype wire

// ==== logic/bcd_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module bcd_alu (
	input  logic              clk,
	input  logic              rst_i,
	input  logic              in_valid_i,
	output logic              in_ready_o,
	input  bcd_pkg::bcd_req_t in_req_i,
	output logic              out_valid_o,
	input  logic              out_ready_i,
	output bcd_pkg::bcd_rsp_t out_rsp_o
);
	import bcd_pkg::*;

	logic                  s1_valid;
	logic                  s1_ready;
	bcd_req_t              s1_req;
	bcd_word_t             digit_sum;
	logic [NUM_DIGITS:0]   carry_chain;   // entry k is the carry into digit k

	// ------------------------------------------------------------
	// stage one
	// ------------------------------------------------------------
	bcd_operand_stage u_operand (
		.clk        (clk),
		.rst_i      (rst_i),
		.in_valid_i (in_valid_i),
		.in_ready_o (in_ready_o),
		.in_req_i   (in_req_i),
		.s1_valid_o (s1_valid),
		.s1_ready_i (s1_ready),
		.s1_req_o   (s1_req)
	);

	// ------------------------------------------------------------
	// ripple chain of decimal digits, lowest digit first
	// ------------------------------------------------------------
	assign carry_chain[0] = s1_req.carry_in;

	for (genvar k = 0; k < NUM_DIGITS; k++) begin : g_digit
		bcd_digit_cell u_cell (
			.a_i     (s1_req.a[k*DIGIT_W +: DIGIT_W]),
			.b_i     (s1_req.b[k*DIGIT_W +: DIGIT_W]),
			.sub_i   (s1_req.sub),
			.carry_i (carry_chain[k]),
			.sum_o   (digit_sum[k*DIGIT_W +: DIGIT_W]),
			.carry_o (carry_chain[k+1])
		);
	end

	// ------------------------------------------------------------
	// stage two
	// ------------------------------------------------------------
	bcd_result_stage u_result (
		.clk          (clk),
		.rst_i        (rst_i),
		.s1_valid_i   (s1_valid),
		.s1_ready_o   (s1_ready),
		.s1_req_i     (s1_req),
		.digit_sum_i  (digit_sum),
		.carry_byte_i (carry_chain[BYTE_DIGITS]),   // out of the second digit
		.carry_word_i (carry_chain[NUM_DIGITS]),
		.out_valid_o  (out_valid_o),
		.out_ready_i  (out_ready_i),
		.out_rsp_o    (out_rsp_o)
	);

endmodule

`default_nettype wire

// ==== bench/clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
	output logic clk_o
);
	localparam realtime HALF_PERIOD = 2.0;   // 4 ns period

	initial begin
		clk_o = 1'b0;
		forever begin
			#(HALF_PERIOD);
			clk_o = ~clk_o;
		end
	end

endmodule

`default_nettype wire

// ==== bench/bcd_alu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module bcd_alu_tb;
	import bcd_pkg::*;

	localparam int NUM_RANDOM     = 500;
	localparam int ACCEPT_TIMEOUT = 100;   // cycles per request
	localparam int DRAIN_TIMEOUT  = 200;
	localparam int PATTERN_LEN    = 1024;

	typedef struct packed {
		bcd_rsp_t    rsp;       // model result
		int unsigned cycle;     // acceptance cycle
		int unsigned idx;
		logic        timed;     // latency is checked
	} exp_t;

	logic     clk;
	logic     rst_i;
	logic     in_valid_i;
	logic     in_ready_o;
	bcd_req_t in_req_i;
	logic     out_valid_o;
	logic     out_ready_i;
	bcd_rsp_t out_rsp_o;

	exp_t        exp_q[$];
	logic        ready_pattern [0:PATTERN_LEN-1];
	int unsigned cycle_cnt      = 0;
	int unsigned req_count      = 0;
	int unsigned rsp_count      = 0;
	int unsigned mismatch_count = 0;
	int unsigned other_count    = 0;
	logic        timed_mode     = 1'b0;
	logic        bp_mode        = 1'b0;

	clock_gen u_clk (.clk_o(clk));

	bcd_alu DUT (
		.clk         (clk),
		.rst_i       (rst_i),
		.in_valid_i  (in_valid_i),
		.in_ready_o  (in_ready_o),
		.in_req_i    (in_req_i),
		.out_valid_o (out_valid_o),
		.out_ready_i (out_ready_i),
		.out_rsp_o   (out_rsp_o)
	);

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------
	function automatic int bcd_to_int(bcd_word_t word, int digits);
		int value;
		value = 0;
		for (int i = digits - 1; i >= 0; i--)
			value = value * 10 + int'(word[i*DIGIT_W +: DIGIT_W]);
		return value;
	endfunction

	function automatic bcd_word_t int_to_bcd(int value, int digits);
		bcd_word_t word;
		word = '0;
		for (int i = 0; i < digits; i++) begin
			word[i*DIGIT_W +: DIGIT_W] = DIGIT_W'(value % 10);
			value = value / 10;
		end
		return word;
	endfunction

	function automatic bcd_rsp_t model_rsp(bcd_req_t req);
		bcd_rsp_t rsp;
		int       digits;
		int       modulus;
		int       res;
		digits  = req.byte_mode ? BYTE_DIGITS : NUM_DIGITS;
		modulus = req.byte_mode ? 100 : 10000;
		if (req.sub) begin
			res = bcd_to_int(req.a, digits) - bcd_to_int(req.b, digits)
			      - (req.carry_in ? 0 : 1);
			rsp.carry = (res >= 0);   // no borrow
			if (res < 0)
				res += modulus;       // tens complement
		end else begin
			res = bcd_to_int(req.a, digits) + bcd_to_int(req.b, digits)
			      + (req.carry_in ? 1 : 0);
			rsp.carry = (res >= modulus);
			if (res >= modulus)
				res -= modulus;
		end
		rsp.sum  = int_to_bcd(res, digits);
		rsp.zero = (res == 0);
		if (req.byte_mode) begin
			rsp.sum[WORD_W-1:BYTE_DIGITS*DIGIT_W] = req.a[WORD_W-1:BYTE_DIGITS*DIGIT_W];
			rsp.negative = rsp.sum[BYTE_DIGITS*DIGIT_W-1];
		end else begin
			rsp.negative = rsp.sum[WORD_W-1];
		end
		return rsp;
	endfunction

	function automatic bcd_req_t make_req(bcd_word_t a, bcd_word_t b, logic sub,
	                                      logic byte_mode, logic carry_in);
		bcd_req_t req;
		req.a         = a;
		req.b         = b;
		req.sub       = sub;
		req.byte_mode = byte_mode;
		req.carry_in  = carry_in;
		return req;
	endfunction

	function automatic bcd_word_t rand_bcd();
		bcd_word_t word;
		for (int i = 0; i < NUM_DIGITS; i++)
			word[i*DIGIT_W +: DIGIT_W] = DIGIT_W'($urandom_range(9, 0));
		return word;
	endfunction

	// ------------------------------------------------------------
	// checks and end of run
	// ------------------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] expected,
	                           input logic [31:0] actual);
		if (expected !== actual) begin
			mismatch_count++;
			$display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual);
		end
	endtask

	task automatic finish_run();
		$display("errors: %0d mismatches, %0d other failures (%0d requests, %0d responses)",
		         mismatch_count, other_count, req_count, rsp_count);
		if (mismatch_count == 0 && other_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	task automatic report_timeout(input string what);
		other_count++;
		$display("timeout: %s", what);
		finish_run();
	endtask

	task automatic compare_rsp(input exp_t entry);
		string tag;
		tag = $sformatf("rsp%0d", entry.idx);
		check_value({tag, ".sum"}, 32'(entry.rsp.sum), 32'(out_rsp_o.sum));
		check_value({tag, ".carry"}, 32'(entry.rsp.carry), 32'(out_rsp_o.carry));
		check_value({tag, ".zero"}, 32'(entry.rsp.zero), 32'(out_rsp_o.zero));
		check_value({tag, ".negative"}, 32'(entry.rsp.negative), 32'(out_rsp_o.negative));
		if (entry.timed)
			check_value({tag, ".latency"}, 32'd2, cycle_cnt - entry.cycle);
		rsp_count++;
	endtask

	// ------------------------------------------------------------
	// monitor, sampled before the DUT registers update
	// ------------------------------------------------------------
	always @(posedge clk) begin
		exp_t entry;
		if (!rst_i) begin
			if (out_valid_o && out_ready_i) begin
				if (exp_q.size() == 0) begin
					other_count++;
					$display("response came out with no request pending");
				end else begin
					entry = exp_q.pop_front();
					compare_rsp(entry);
				end
			end
			if (in_valid_i && in_ready_o) begin
				entry.rsp   = model_rsp(in_req_i);
				entry.cycle = cycle_cnt;
				entry.idx   = req_count;
				entry.timed = timed_mode;
				exp_q.push_back(entry);
				req_count++;
			end
		end
		cycle_cnt++;
	end

	// random back-pressure on the response side
	always @(negedge clk) begin
		if (bp_mode)
			out_ready_i = ready_pattern[cycle_cnt % PATTERN_LEN];
		else
			out_ready_i = 1'b1;
	end

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	task automatic send_req(input bcd_req_t req, output int waited);
		logic accepted;
		accepted = 1'b0;
		waited   = 0;
		@(negedge clk);
		in_valid_i = 1'b1;
		in_req_i   = req;
		while (!accepted) begin
			@(posedge clk);
			if (in_ready_o) begin
				accepted = 1'b1;
			end else begin
				waited++;
				if (waited > ACCEPT_TIMEOUT)
					report_timeout("request was never accepted");
			end
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		@(negedge clk);
		in_valid_i = 1'b0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
			waited++;
			if (waited > DRAIN_TIMEOUT)
				report_timeout("pending responses never came out");
		end
	endtask

	initial begin
		bcd_req_t directed[$];
		bcd_req_t req;
		int       waited;
		int       gap;

		rst_i       = 1'b1;
		in_valid_i  = 1'b0;
		in_req_i    = '0;
		out_ready_i = 1'b1;
		void'($urandom(32'hd8e5));
		for (int i = 0; i < PATTERN_LEN; i++)
			ready_pattern[i] = ($urandom_range(99, 0) < 60);

		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_i      = 1'b0;
		timed_mode = 1'b1;

		// corner cases, back to back with the output always ready
		directed.push_back(make_req(16'h1234, 16'h4321, 1'b0, 1'b0, 1'b0));
		directed.push_back(make_req(16'h9999, 16'h0001, 1'b0, 1'b0, 1'b0));   // zero with carry
		directed.push_back(make_req(16'h5000, 16'h5000, 1'b0, 1'b0, 1'b1));
		directed.push_back(make_req(16'h8765, 16'h4321, 1'b0, 1'b0, 1'b1));
		directed.push_back(make_req(16'h5000, 16'h1234, 1'b1, 1'b0, 1'b1));
		directed.push_back(make_req(16'h1234, 16'h5000, 1'b1, 1'b0, 1'b1));   // wraps
		directed.push_back(make_req(16'h0000, 16'h0000, 1'b1, 1'b0, 1'b0));
		directed.push_back(make_req(16'h4321, 16'h4321, 1'b1, 1'b0, 1'b1));
		directed.push_back(make_req(16'h1299, 16'h7701, 1'b0, 1'b1, 1'b0));   // byte carry
		directed.push_back(make_req(16'h4510, 16'h3320, 1'b1, 1'b1, 1'b1));
		directed.push_back(make_req(16'h9945, 16'h0032, 1'b0, 1'b1, 1'b1));
		directed.push_back(make_req(16'h8000, 16'h0000, 1'b1, 1'b1, 1'b0));
		foreach (directed[i]) begin
			send_req(directed[i], waited);
			check_value($sformatf("directed%0d.accept_wait", i), 32'd0, waited);
		end
		wait_drain();

		// random operands under random back-pressure
		timed_mode = 1'b0;
		@(posedge clk);
		bp_mode = 1'b1;
		for (int n = 0; n < NUM_RANDOM; n++) begin
			req.a         = rand_bcd();
			req.b         = ($urandom_range(7, 0) == 0) ? req.a : rand_bcd();
			req.sub       = $urandom_range(1, 0);
			req.byte_mode = $urandom_range(1, 0);
			req.carry_in  = $urandom_range(1, 0);
			if ($urandom_range(3, 0) == 0) begin
				gap = $urandom_range(3, 1);
				@(negedge clk);
				in_valid_i = 1'b0;
				repeat (gap - 1) @(negedge clk);
			end
			send_req(req, waited);
		end
		bp_mode = 1'b0;
		wait_drain();

		check_value("request_count", directed.size() + NUM_RANDOM, req_count);
		finish_run();
	end

endmodule

`default_nettype wire

// ==== files.f ====
logic/bcd_pkg.sv
logic/bcd_operand_stage.sv
logic/bcd_digit_cell.sv
logic/bcd_result_stage.sv
logic/bcd_alu.sv
bench/clock_gen.sv
bench/bcd_alu_tb.sv
